/* source/hello_pkg.sv */
// Shared constants and state types for the hello-world register path
// All register addresses are byte addresses on the BAR0 AXI-Lite window
// ID words are placeholders and must be replaced by the card's real PCI IDs

package hello_pkg;

  // --------------------
  // Register map

  // Greeting register, reads back byte-swapped
  localparam logic [31:0] hello_reg_addr = 32'h0000_0500;

  // Virtual LED shadow, low 16 bits only
  localparam logic [31:0] vled_reg_addr = 32'h0000_0504;

  // Returned for any unmapped read
  localparam logic [31:0] unimpl_reg_value = 32'hDEAD_BEEF;

  // --------------------
  // ID and status words

  // Device ID in [31:16], vendor ID in [15:0]
  localparam logic [31:0] cl_id0_value = 32'hF000_1234;

  // Subsystem ID in [31:16], subsystem vendor ID in [15:0]
  localparam logic [31:0] cl_id1_value = 32'h1D51_1234;

  localparam logic [31:0] cl_status0_value = 32'h0000_0FF0;
  localparam logic [31:0] cl_version_value = 32'hEEEE_EE00;

  // --------------------
  // Slave sequencer states

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_lookup,
    rd_resp
  } rd_state_e;

endpackage

/* source/axil_if.sv */
// AXI-Lite bundle with 32-bit address and data
// Single-beat only, so no id, len, last or user fields
// Valid and payload hold steady until the matching ready

interface axil_if;

  // Write address channel
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;

  // Write data channel
  logic        wvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wready;

  // Write response channel
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;

  // Read address channel
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;

  // Read data channel
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

/* source/reg_bus_if.sv */
// Simple register bus between the AXI-Lite slave and the register block
// wr_en is a one-cycle pulse with address, data and strobe valid alongside
// rd_data is combinational from rd_addr with no wait states

interface reg_bus_if;

  // Write side
  logic        wr_en;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;

  // Read side
  logic [31:0] rd_addr;
  logic [31:0] rd_data;

  // Bus sequencer end
  modport ctrl (
    output wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    input  rd_data
  );

  // Register block end
  modport regs (
    input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
    output rd_data
  );

endinterface

/* source/axil_reg_slice.sv */
// Registered AXI-Lite stage with a two-entry buffer per channel
// Adds at least one cycle of latency on every channel
// Ready toward the source depends only on buffer fill, never on the far side

module axil_reg_slice (
  input logic     clk_main_a0,
  input logic     rst_main_n_sync,
  axil_if.slave   up,
  axil_if.master  dn
);

  // Channel index 0 aw, 1 w, 2 ar, 3 b, 4 r
  // Payloads padded to the widest channel (wstrb plus wdata)
  logic        src_valid [5];
  logic        src_ready [5];
  logic [35:0] src_data  [5];
  logic        dst_valid [5];
  logic        dst_ready [5];
  logic [35:0] dst_data  [5];

  // --------------------
  // Forward channels, up to dn

  assign src_valid[0] = up.awvalid;
  assign src_data[0]  = {4'b0000, up.awaddr};
  assign up.awready   = src_ready[0];
  assign dn.awvalid   = dst_valid[0];
  assign dn.awaddr    = dst_data[0][31:0];
  assign dst_ready[0] = dn.awready;

  assign src_valid[1] = up.wvalid;
  assign src_data[1]  = {up.wstrb, up.wdata};
  assign up.wready    = src_ready[1];
  assign dn.wvalid    = dst_valid[1];
  assign dn.wdata     = dst_data[1][31:0];
  assign dn.wstrb     = dst_data[1][35:32];
  assign dst_ready[1] = dn.wready;

  assign src_valid[2] = up.arvalid;
  assign src_data[2]  = {4'b0000, up.araddr};
  assign up.arready   = src_ready[2];
  assign dn.arvalid   = dst_valid[2];
  assign dn.araddr    = dst_data[2][31:0];
  assign dst_ready[2] = dn.arready;

  // --------------------
  // Return channels, dn to up

  assign src_valid[3] = dn.bvalid;
  assign src_data[3]  = {34'd0, dn.bresp};
  assign dn.bready    = src_ready[3];
  assign up.bvalid    = dst_valid[3];
  assign up.bresp     = dst_data[3][1:0];
  assign dst_ready[3] = up.bready;

  assign src_valid[4] = dn.rvalid;
  assign src_data[4]  = {2'b00, dn.rresp, dn.rdata};
  assign dn.rready    = src_ready[4];
  assign up.rvalid    = dst_valid[4];
  assign up.rdata     = dst_data[4][31:0];
  assign up.rresp     = dst_data[4][33:32];
  assign dst_ready[4] = up.rready;

  // --------------------
  // Per-channel two-entry buffer

  for (genvar ch = 0; ch < 5; ch++) begin : g_chan
    logic [35:0] mem [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  count;
    logic        push;
    logic        pop;

    // Space left means ready, so the source never sees the sink's ready
    assign src_ready[ch] = (count != 2'd2);
    assign dst_valid[ch] = (count != 2'd0);
    assign dst_data[ch]  = mem[rd_ptr];

    assign push = src_valid[ch] && src_ready[ch];
    assign pop  = dst_valid[ch] && dst_ready[ch];

    // Payload storage
    always_ff @(posedge clk_main_a0) begin
      if (push) begin
        mem[wr_ptr] <= src_data[ch];
      end
    end

    // Pointers and fill level
    always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
        wr_ptr <= 1'b0;
        rd_ptr <= 1'b0;
        count  <= 2'd0;
      end else begin
        if (push) begin
          wr_ptr <= ~wr_ptr;
        end
        if (pop) begin
          rd_ptr <= ~rd_ptr;
        end
        // Simultaneous push and pop leaves the level alone
        case ({push, pop})
          2'b10:   count <= count + 2'd1;
          2'b01:   count <= count - 2'd1;
          default: count <= count;
        endcase
      end
    end
  end

endmodule

/* source/ocl_slave.sv */
// Single-beat AXI-Lite slave onto the register bus
// One write and one read outstanding at a time, each sequenced independently
// Responses are always OKAY, unmapped addresses are resolved by the registers

module ocl_slave (
  input logic      clk_main_a0,
  input logic      rst_main_n_sync,
  axil_if.slave    axil,
  reg_bus_if.ctrl  regs
);

  import hello_pkg::*;

  wr_state_e   wr_state;
  logic [31:0] wr_addr_q;
  logic        aw_fire;
  logic        w_fire;
  logic        b_fire;

  rd_state_e   rd_state;
  logic [31:0] rd_addr_q;
  logic [31:0] rdata_q;
  logic        ar_fire;
  logic        r_fire;

  // --------------------
  // Write sequencer

  assign aw_fire = axil.awvalid && axil.awready;
  assign w_fire  = axil.wvalid && axil.wready;
  assign b_fire  = axil.bvalid && axil.bready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= wr_idle;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (aw_fire) begin
            wr_state <= wr_data;
          end
        end
        // Data beat goes out as the wr_en pulse
        wr_data: begin
          if (w_fire) begin
            wr_state <= wr_resp;
          end
        end
        wr_resp: begin
          if (b_fire) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // Address held for the data beat
  always_ff @(posedge clk_main_a0) begin
    if (aw_fire) begin
      wr_addr_q <= axil.awaddr;
    end
  end

  assign axil.awready = (wr_state == wr_idle);
  assign axil.wready  = (wr_state == wr_data);
  assign axil.bvalid  = (wr_state == wr_resp);
  assign axil.bresp   = 2'b00;

  assign regs.wr_en   = w_fire;
  assign regs.wr_addr = wr_addr_q;
  assign regs.wr_data = axil.wdata;
  assign regs.wr_strb = axil.wstrb;

  // --------------------
  // Read sequencer

  assign ar_fire = axil.arvalid && axil.arready;
  assign r_fire  = axil.rvalid && axil.rready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (ar_fire) begin
            rd_state <= rd_lookup;
          end
        end
        // Single cycle on the bus, always advances
        rd_lookup: rd_state <= rd_resp;
        rd_resp: begin
          if (r_fire) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // Latch address, then sample the mux result at the end of lookup
  always_ff @(posedge clk_main_a0) begin
    if (ar_fire) begin
      rd_addr_q <= axil.araddr;
    end
    if (rd_state == rd_lookup) begin
      rdata_q <= regs.rd_data;
    end
  end

  assign regs.rd_addr = rd_addr_q;

  assign axil.arready = (rd_state == rd_idle);
  assign axil.rvalid  = (rd_state == rd_resp);
  assign axil.rdata   = rdata_q;
  assign axil.rresp   = 2'b00;

endmodule

/* source/hello_regs.sv */
// Greeting and virtual LED registers behind the register bus
// Only the greeting register is writable, other write addresses are dropped
// LED output is masked by the DIP inputs, the LED readback is not

module hello_regs (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  reg_bus_if.regs     bus,
  input  logic [15:0] vdip,
  output logic [15:0] vled
);

  import hello_pkg::*;

  logic [31:0] greeting_q;
  logic [31:0] greeting_swapped;
  logic [15:0] vled_q;
  logic        greeting_wr;

  // --------------------
  // Greeting register

  assign greeting_wr = bus.wr_en && (bus.wr_addr == hello_reg_addr);

  // Byte lanes follow wr_strb
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      greeting_q <= 32'd0;
    end else if (greeting_wr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus.wr_strb[lane]) begin
          greeting_q[8*lane +: 8] <= bus.wr_data[8*lane +: 8];
        end
      end
    end
  end

  // Reads come back with byte order reversed
  assign greeting_swapped = {greeting_q[7:0], greeting_q[15:8],
                             greeting_q[23:16], greeting_q[31:24]};

  // --------------------
  // Virtual LEDs

  // Shadow of greeting low half, one cycle behind
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= 16'd0;
    end else begin
      vled_q <= greeting_q[15:0];
    end
  end

  // DIP switches gate each LED
  assign vled = vled_q & vdip;

  // --------------------
  // Read mux

  always_comb begin
    if (bus.rd_addr == hello_reg_addr) begin
      bus.rd_data = greeting_swapped;
    end else if (bus.rd_addr == vled_reg_addr) begin
      bus.rd_data = {16'd0, vled_q};
    end else begin
      bus.rd_data = unimpl_reg_value;
    end
  end

endmodule

/* source/cl_hello_world.sv */
// Custom-logic top for the hello-world BAR0 register path
// rst_main_n_sync must already be synchronous to clk_main_a0
// Host accesses are single-beat AXI-Lite, responses always OKAY

module cl_hello_world (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,

  // Host BAR0 AXI-Lite
  input  logic        sh_ocl_awvalid,
  input  logic [31:0] sh_ocl_awaddr,
  output logic        ocl_sh_awready,
  input  logic        sh_ocl_wvalid,
  input  logic [31:0] sh_ocl_wdata,
  input  logic [3:0]  sh_ocl_wstrb,
  output logic        ocl_sh_wready,
  output logic        ocl_sh_bvalid,
  output logic [1:0]  ocl_sh_bresp,
  input  logic        sh_ocl_bready,
  input  logic        sh_ocl_arvalid,
  input  logic [31:0] sh_ocl_araddr,
  output logic        ocl_sh_arready,
  output logic        ocl_sh_rvalid,
  output logic [31:0] ocl_sh_rdata,
  output logic [1:0]  ocl_sh_rresp,
  input  logic        sh_ocl_rready,

  // Virtual switches, LEDs, ID and status
  input  logic [15:0] sh_cl_status_vdip,
  output logic [15:0] cl_sh_status_vled,
  output logic [31:0] cl_sh_id0,
  output logic [31:0] cl_sh_id1,
  output logic [31:0] cl_sh_status0,
  output logic [31:0] cl_sh_status1
);

  import hello_pkg::*;

  // Host side of the slice and core side behind it
  axil_if    host_axil ();
  axil_if    core_axil ();
  reg_bus_if reg_bus ();

  // --------------------
  // Host port mapping

  assign host_axil.awvalid = sh_ocl_awvalid;
  assign host_axil.awaddr  = sh_ocl_awaddr;
  assign host_axil.wvalid  = sh_ocl_wvalid;
  assign host_axil.wdata   = sh_ocl_wdata;
  assign host_axil.wstrb   = sh_ocl_wstrb;
  assign host_axil.bready  = sh_ocl_bready;
  assign host_axil.arvalid = sh_ocl_arvalid;
  assign host_axil.araddr  = sh_ocl_araddr;
  assign host_axil.rready  = sh_ocl_rready;

  assign ocl_sh_awready = host_axil.awready;
  assign ocl_sh_wready  = host_axil.wready;
  assign ocl_sh_bvalid  = host_axil.bvalid;
  assign ocl_sh_bresp   = host_axil.bresp;
  assign ocl_sh_arready = host_axil.arready;
  assign ocl_sh_rvalid  = host_axil.rvalid;
  assign ocl_sh_rdata   = host_axil.rdata;
  assign ocl_sh_rresp   = host_axil.rresp;

  // Fixed identification and status
  assign cl_sh_id0     = cl_id0_value;
  assign cl_sh_id1     = cl_id1_value;
  assign cl_sh_status0 = cl_status0_value;
  assign cl_sh_status1 = cl_version_value;

  // --------------------
  // Datapath

  axil_reg_slice u_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .up              (host_axil.slave),
    .dn              (core_axil.master)
  );

  ocl_slave u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil            (core_axil.slave),
    .regs            (reg_bus.ctrl)
  );

  hello_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (reg_bus.regs),
    .vdip            (sh_cl_status_vdip),
    .vled            (cl_sh_status_vled)
  );

endmodule

/* testbench/tb_cl_hello_world.sv */
// Pattern-driven testbench for the BAR0 register path
// Needs testbench/hello_patterns.txt, read relative to the project root
// Host stimulus changes on the rising edge and DUT outputs are sampled on the falling edge

module tb_cl_hello_world;

  import hello_pkg::*;

  localparam int pattern_depth = 64;

  logic        clk_main_a0 = 1'b0;
  logic        rst_main_n_sync;
  logic        sh_ocl_awvalid;
  logic [31:0] sh_ocl_awaddr;
  logic        sh_ocl_wvalid;
  logic [31:0] sh_ocl_wdata;
  logic [3:0]  sh_ocl_wstrb;
  logic        sh_ocl_bready;
  logic        sh_ocl_arvalid;
  logic [31:0] sh_ocl_araddr;
  logic        sh_ocl_rready;
  logic [15:0] sh_cl_status_vdip;
  logic        ocl_sh_awready;
  logic        ocl_sh_wready;
  logic        ocl_sh_bvalid;
  logic [1:0]  ocl_sh_bresp;
  logic        ocl_sh_arready;
  logic        ocl_sh_rvalid;
  logic [31:0] ocl_sh_rdata;
  logic [1:0]  ocl_sh_rresp;
  logic [15:0] cl_sh_status_vled;
  logic [31:0] cl_sh_id0;
  logic [31:0] cl_sh_id1;
  logic [31:0] cl_sh_status0;
  logic [31:0] cl_sh_status1;

  // Op nibble, address, data, strobe, DIP, expected
  logic [119:0] patterns [pattern_depth];
  logic [31:0]  greeting_model;
  logic [31:0]  rng_state = 32'd73;
  int           cycle_count = 0;
  int           cycle_limit = 64 * pattern_depth + 200;

  always #20 clk_main_a0 = ~clk_main_a0;

  cl_hello_world UUT (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .sh_ocl_awvalid    (sh_ocl_awvalid),
    .sh_ocl_awaddr     (sh_ocl_awaddr),
    .ocl_sh_awready    (ocl_sh_awready),
    .sh_ocl_wvalid     (sh_ocl_wvalid),
    .sh_ocl_wdata      (sh_ocl_wdata),
    .sh_ocl_wstrb      (sh_ocl_wstrb),
    .ocl_sh_wready     (ocl_sh_wready),
    .ocl_sh_bvalid     (ocl_sh_bvalid),
    .ocl_sh_bresp      (ocl_sh_bresp),
    .sh_ocl_bready     (sh_ocl_bready),
    .sh_ocl_arvalid    (sh_ocl_arvalid),
    .sh_ocl_araddr     (sh_ocl_araddr),
    .ocl_sh_arready    (ocl_sh_arready),
    .ocl_sh_rvalid     (ocl_sh_rvalid),
    .ocl_sh_rdata      (ocl_sh_rdata),
    .ocl_sh_rresp      (ocl_sh_rresp),
    .sh_ocl_rready     (sh_ocl_rready),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled),
    .cl_sh_id0         (cl_sh_id0),
    .cl_sh_id1         (cl_sh_id1),
    .cl_sh_status0     (cl_sh_status0),
    .cl_sh_status1     (cl_sh_status1)
  );

  // --------------------
  // Reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Read value the register map should give
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if (addr == hello_reg_addr) begin
      return swap_bytes(greeting_model);
    end else if (addr == vled_reg_addr) begin
      return {16'h0000, greeting_model[15:0]};
    end
    return unimpl_reg_value;
  endfunction

  // Writes reach only the greeting register and follow the strobe lanes
  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr == hello_reg_addr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
          greeting_model[8*lane +: 8] = data[8*lane +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  // --------------------
  // Host AXI-Lite tasks

  task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] bresp);
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    int   stall;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b1;
    sh_ocl_awaddr  <= addr;
    sh_ocl_wvalid  <= 1'b1;
    sh_ocl_wdata   <= data;
    sh_ocl_wstrb   <= strb;
    // Address and data may be taken on different edges
    do begin
      @(negedge clk_main_a0);
      aw_hs = sh_ocl_awvalid && ocl_sh_awready;
      w_hs  = sh_ocl_wvalid && ocl_sh_wready;
      @(posedge clk_main_a0);
      if (aw_hs) begin
        sh_ocl_awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        sh_ocl_wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end while (!(aw_done && w_done));
    do begin
      @(negedge clk_main_a0);
    end while (!ocl_sh_bvalid);
    bresp = ocl_sh_bresp;
    rng_state = xorshift32(rng_state);
    stall = int'(rng_state % 32'd8);
    // Response must hold while bready stays low
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("ocl_sh_bvalid", {31'h0, ocl_sh_bvalid}, 32'h1);
      check_value("ocl_sh_bresp", {30'h0, ocl_sh_bresp}, {30'h0, bresp});
    end
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b1;
    @(negedge clk_main_a0);
    check_value("ocl_sh_bvalid", {31'h0, ocl_sh_bvalid}, 32'h1);
    @(posedge clk_main_a0);
    sh_ocl_bready <= 1'b0;
    // One access, one response
    @(negedge clk_main_a0);
    check_value("ocl_sh_bvalid", {31'h0, ocl_sh_bvalid}, 32'h0);
  endtask

  task automatic read_access(input logic [31:0] addr, output logic [31:0] data);
    logic accepted;
    int   stall;
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b1;
    sh_ocl_araddr  <= addr;
    do begin
      @(negedge clk_main_a0);
      accepted = ocl_sh_arready;
      @(posedge clk_main_a0);
    end while (!accepted);
    sh_ocl_arvalid <= 1'b0;
    do begin
      @(negedge clk_main_a0);
    end while (!ocl_sh_rvalid);
    data = ocl_sh_rdata;
    check_value("ocl_sh_rresp", {30'h0, ocl_sh_rresp}, 32'h0);
    rng_state = xorshift32(rng_state);
    stall = int'(rng_state % 32'd8);
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("ocl_sh_rvalid", {31'h0, ocl_sh_rvalid}, 32'h1);
      check_value("ocl_sh_rdata", ocl_sh_rdata, data);
    end
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b1;
    @(negedge clk_main_a0);
    check_value("ocl_sh_rvalid", {31'h0, ocl_sh_rvalid}, 32'h1);
    check_value("ocl_sh_rdata", ocl_sh_rdata, data);
    @(posedge clk_main_a0);
    sh_ocl_rready <= 1'b0;
    @(negedge clk_main_a0);
    check_value("ocl_sh_rvalid", {31'h0, ocl_sh_rvalid}, 32'h0);
  endtask

  // --------------------
  // Watchdog

  always @(posedge clk_main_a0) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no progress after %0d cycles", cycle_count);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  // --------------------
  // Main sequence

  initial begin
    int          num_lines;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [15:0] dip;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic [1:0]  bresp;
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = 32'h0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = 32'h0;
    sh_ocl_wstrb      = 4'h0;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = 32'h0;
    sh_ocl_rready     = 1'b0;
    sh_cl_status_vdip = 16'hFFFF;
    greeting_model    = 32'h0;
    $readmemh("testbench/hello_patterns.txt", patterns);
    // Lines end at the op F marker
    num_lines = 0;
    while (num_lines < pattern_depth && patterns[num_lines][119:116] !== 4'hF) begin
      num_lines++;
    end
    if (num_lines == 0 || num_lines == pattern_depth) begin
      $display("Pattern file is empty or has no end marker line");
      $display("Result: FAILED");
      $fatal(1);
    end
    cycle_limit = 64 * num_lines + 200;
    repeat (10) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(negedge clk_main_a0);
    check_value("cl_sh_id0", cl_sh_id0, cl_id0_value);
    check_value("cl_sh_id1", cl_sh_id1, cl_id1_value);
    check_value("cl_sh_status0", cl_sh_status0, cl_status0_value);
    check_value("cl_sh_status1", cl_sh_status1, cl_version_value);
    check_value("cl_sh_status_vled", {16'h0, cl_sh_status_vled}, 32'h0);
    // Empty slice buffers accept on every request channel
    check_value("ocl_sh_awready", {31'h0, ocl_sh_awready}, 32'h1);
    check_value("ocl_sh_wready", {31'h0, ocl_sh_wready}, 32'h1);
    check_value("ocl_sh_arready", {31'h0, ocl_sh_arready}, 32'h1);
    for (int i = 0; i < num_lines; i++) begin
      {op, addr, data, strb, dip, expected} = patterns[i];
      @(posedge clk_main_a0);
      sh_cl_status_vdip <= dip;
      case (op)
        4'h1: begin
          write_access(addr, data, strb, bresp);
          check_value("ocl_sh_bresp", {30'h0, bresp}, expected);
          apply_write(addr, data, strb);
        end
        4'h2: begin
          read_access(addr, rdata);
          check_value("ocl_sh_rdata", rdata, expected_read(addr));
          check_value("ocl_sh_rdata", rdata, expected);
        end
        // LED shadow needs a few idle cycles to settle
        4'h3: begin
          repeat (4) @(posedge clk_main_a0);
          @(negedge clk_main_a0);
          check_value("cl_sh_status_vled", {16'h0, cl_sh_status_vled},
                      {16'h0, greeting_model[15:0] & dip});
          check_value("cl_sh_status_vled", {16'h0, cl_sh_status_vled}, expected);
        end
        default: begin
          $display("Pattern line %0d has an unknown operation code %0h", i, op);
          $display("Result: FAILED");
          $fatal(1);
        end
      endcase
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* testbench/hello_patterns.txt */
// Columns: op _ address _ data _ strobe _ DIP _ expected
// op 1 write (expected bresp), 2 read (expected rdata), 3 LED check (expected vled), F end
2_00000500_00000000_0_FFFF_00000000
3_00000000_00000000_0_FFFF_00000000
1_00000500_12345678_F_FFFF_00000000
2_00000500_00000000_0_FFFF_78563412
3_00000000_00000000_0_FFFF_00005678
2_00000504_00000000_0_FFFF_00005678
1_00000500_AABBCCDD_5_FFFF_00000000
2_00000500_00000000_0_FFFF_DD56BB12
3_00000000_00000000_0_0F0F_0000060D
2_00000504_00000000_0_0F0F_000056DD
1_00000500_00009900_2_FFFF_00000000
2_00000500_00000000_0_FFFF_DD99BB12
3_00000000_00000000_0_F0F0_000090D0
2_00000600_00000000_0_FFFF_DEADBEEF
1_00000600_FFFFFFFF_F_FFFF_00000000
2_00000500_00000000_0_FFFF_DD99BB12
1_00000504_0000FFFF_F_FFFF_00000000
2_00000504_00000000_0_FFFF_000099DD
1_00000500_CAFEF00D_C_FFFF_00000000
2_00000500_00000000_0_FFFF_DD99FECA
3_00000000_00000000_0_FFFF_000099DD
2_00000508_00000000_0_FFFF_DEADBEEF
F_00000000_00000000_0_0000_00000000

/* list.f */
source/hello_pkg.sv
source/axil_if.sv
source/reg_bus_if.sv
source/axil_reg_slice.sv
source/ocl_slave.sv
source/hello_regs.sv
source/cl_hello_world.sv
testbench/tb_cl_hello_world.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cl_hello_world -f list.f -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
